// ==== source/conv_types_pkg.sv ====
package conv_types_pkg;

  // Kernel geometry
  localparam int kdim = 5;
  localparam int taps = kdim * kdim;

  // Scalar widths on the data path
  typedef logic [5:0]  pixel_t;
  typedef logic [5:0]  coef_t;
  typedef logic [11:0] product_t;
  typedef logic [17:0] conv_sum_t;

  // Index r*kdim+c is the pixel at (row-4+r, col-4+c) of the newest pixel
  typedef struct packed {
    logic                  valid;
    pixel_t [taps-1:0]     pix;
  } window_t;

  // Same index order as the window
  typedef coef_t [taps-1:0] kernel_t;

  typedef struct packed {
    logic      valid;
    conv_sum_t sum;
  } result_t;

endpackage

// ==== source/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

  // Host command opcodes
  typedef enum logic [1:0] {
    op_kernel_begin = 2'd0,
    op_coef         = 2'd1,
    op_frame_start  = 2'd2,
    op_pixel        = 2'd3
  } cmd_op_e;

  // Sequencer states
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_load   = 2'd1,
    st_stream = 2'd2
  } seq_state_e;

  // One host command, acted on while valid is high
  typedef struct packed {
    logic       valid;
    cmd_op_e    op;
    logic [5:0] data;
  } cmd_t;

endpackage

// ==== source/shift_add_mult.sv ====
`timescale 1ns/1ps

module shift_add_mult (
  input  conv_types_pkg::pixel_t   a,
  input  conv_types_pkg::coef_t    b,
  output conv_types_pkg::product_t p
);

  conv_types_pkg::product_t acc;

  // Add a shifted copy of a for every set bit of b
  always_comb begin
    acc = '0;
    for (int i = 0; i < $bits(conv_types_pkg::coef_t); i++) begin
      if (b[i]) begin
        acc = acc + (conv_types_pkg::product_t'(a) << i);
      end
    end
  end

  assign p = acc;

endmodule

// ==== source/adder_tree.sv ====
`timescale 1ns/1ps

module adder_tree (
  input  logic                                                clk,
  input  logic                                                rst,
  input  conv_types_pkg::product_t [conv_types_pkg::taps-1:0] products,
  input  logic                                                valid_in,
  output conv_types_pkg::result_t                             sum
);

  conv_types_pkg::conv_sum_t lvl1 [13];
  conv_types_pkg::conv_sum_t lvl2 [7];
  conv_types_pkg::conv_sum_t lvl3 [4];
  conv_types_pkg::conv_sum_t lvl4 [2];
  conv_types_pkg::conv_sum_t sum_q;
  logic                      valid_q;

  // Pairwise levels, the odd element passes through
  always_comb begin
    for (int i = 0; i < 12; i++) begin
      lvl1[i] = conv_types_pkg::conv_sum_t'(products[2*i])
              + conv_types_pkg::conv_sum_t'(products[2*i+1]);
    end
    lvl1[12] = conv_types_pkg::conv_sum_t'(products[24]);
    for (int i = 0; i < 6; i++) begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
    lvl2[6] = lvl1[12];
    for (int i = 0; i < 3; i++) begin
      lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
    end
    lvl3[3] = lvl2[6];
    lvl4[0] = lvl3[0] + lvl3[1];
    lvl4[1] = lvl3[2] + lvl3[3];
  end

  always_ff @(posedge clk) begin
    sum_q <= lvl4[0] + lvl4[1];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_in;
    end
  end

  assign sum = '{valid: valid_q, sum: sum_q};

endmodule

// ==== source/conv55_clb.sv ====
`timescale 1ns/1ps

module conv55_clb (
  input  logic                    clk,
  input  logic                    rst,
  input  conv_types_pkg::window_t window,
  input  conv_types_pkg::kernel_t kernel,
  output conv_types_pkg::result_t result
);

  conv_types_pkg::product_t [conv_types_pkg::taps-1:0] products;

  // One multiplier per tap, window tap i against coefficient i
  genvar i;
  generate
    for (i = 0; i < conv_types_pkg::taps; i++) begin : g_tap
      shift_add_mult u_mult (
        .a (window.pix[i]),
        .b (kernel[i]),
        .p (products[i])
      );
    end
  endgenerate

  // Valid rides with its window so it leaves with the matching sum
  adder_tree u_tree (
    .clk      (clk),
    .rst      (rst),
    .products (products),
    .valid_in (window.valid),
    .sum      (result)
  );

endmodule

// ==== source/line_window.sv ====
`timescale 1ns/1ps

module line_window #(
  parameter int img_width = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pixel_push,
  input  conv_types_pkg::pixel_t  pixel,
  input  logic                    win_ok,
  output conv_types_pkg::window_t window
);

  localparam int kdim  = conv_types_pkg::kdim;
  localparam int ptr_w = (img_width > 1) ? $clog2(img_width) : 1;

  logic [ptr_w-1:0]                                   wr_ptr;
  conv_types_pkg::pixel_t                             lines [kdim-1][img_width];
  conv_types_pkg::pixel_t                             col_in [kdim];
  conv_types_pkg::pixel_t [conv_types_pkg::taps-1:0] win_pix;
  logic                                               win_valid;

  // New right column, lines[0] holds the row just above
  always_comb begin
    col_in[kdim-1] = pixel;
    for (int r = 0; r < kdim-1; r++) begin
      col_in[kdim-2-r] = lines[r][wr_ptr];
    end
  end

  // Chained delay lines of img_width pushes each
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      for (int l = 0; l < kdim-1; l++) begin
        for (int i = 0; i < img_width; i++) begin
          lines[l][i] <= '0;
        end
      end
    end else if (pixel_push) begin
      wr_ptr <= (wr_ptr == ptr_w'(img_width-1)) ? '0 : wr_ptr + 1'b1;
      lines[0][wr_ptr] <= pixel;
      for (int l = 1; l < kdim-1; l++) begin
        lines[l][wr_ptr] <= lines[l-1][wr_ptr];
      end
    end
  end

  // Shift window left one column on each push
  always_ff @(posedge clk) begin
    if (pixel_push) begin
      for (int r = 0; r < kdim; r++) begin
        for (int c = 0; c < kdim-1; c++) begin
          win_pix[r*kdim+c] <= win_pix[r*kdim+c+1];
        end
        win_pix[r*kdim+kdim-1] <= col_in[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= pixel_push & win_ok;
    end
  end

  assign window = '{valid: win_valid, pix: win_pix};

endmodule

// ==== source/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl #(
  parameter int img_width = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  conv_ctrl_pkg::cmd_t     cmd,
  output logic                    pixel_push,
  output conv_types_pkg::pixel_t  pixel,
  output logic                    win_ok,
  output conv_types_pkg::kernel_t kernel,
  output logic                    kernel_ready
);

  localparam int kdim  = conv_types_pkg::kdim;
  localparam int taps  = conv_types_pkg::taps;
  localparam int col_w = (img_width > 1) ? $clog2(img_width) : 1;
  localparam int row_w = $clog2(kdim);
  localparam int idx_w = $clog2(taps);

  conv_ctrl_pkg::seq_state_e state;
  logic [idx_w-1:0]          load_idx;
  logic [col_w-1:0]          col;
  logic [row_w-1:0]          row;
  logic                      do_coef;

  // Pixel strobe goes straight to the window in the same cycle
  assign pixel_push = cmd.valid && cmd.op == conv_ctrl_pkg::op_pixel &&
                      state == conv_ctrl_pkg::st_stream;
  assign pixel      = cmd.data;
  // Row counter saturates at kdim-1, so equality means enough rows
  assign win_ok     = pixel_push && row == row_w'(kdim-1) && col >= col_w'(kdim-1);
  assign do_coef    = cmd.valid && cmd.op == conv_ctrl_pkg::op_coef &&
                      state == conv_ctrl_pkg::st_load;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= conv_ctrl_pkg::st_idle;
      load_idx     <= '0;
      kernel_ready <= 1'b0;
      col          <= '0;
      row          <= '0;
    end else if (cmd.valid) begin
      case (cmd.op)
        conv_ctrl_pkg::op_kernel_begin: begin
          state        <= conv_ctrl_pkg::st_load;
          load_idx     <= '0;
          kernel_ready <= 1'b0;
        end
        conv_ctrl_pkg::op_coef: begin
          if (do_coef) begin
            if (load_idx == idx_w'(taps-1)) begin
              state        <= conv_ctrl_pkg::st_idle;
              kernel_ready <= 1'b1;
            end else begin
              load_idx <= load_idx + 1'b1;
            end
          end
        end
        conv_ctrl_pkg::op_frame_start: begin
          state <= conv_ctrl_pkg::st_stream;
          col   <= '0;
          row   <= '0;
        end
        default: begin
          if (pixel_push) begin
            if (col == col_w'(img_width-1)) begin
              col <= '0;
              if (row != row_w'(kdim-1)) begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Coefficient store
  always_ff @(posedge clk) begin
    if (rst) begin
      kernel <= '0;
    end else if (do_coef) begin
      kernel[load_idx] <= cmd.data;
    end
  end

endmodule

// ==== source/conv_engine_top.sv ====
`timescale 1ns/1ps

module conv_engine_top #(
  parameter int img_width = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  conv_ctrl_pkg::cmd_t     cmd,
  output conv_types_pkg::result_t result,
  output logic                    kernel_ready
);

  logic                    pixel_push;
  conv_types_pkg::pixel_t  pixel;
  logic                    win_ok;
  conv_types_pkg::kernel_t kernel;
  conv_types_pkg::window_t window;

  conv_ctrl #(
    .img_width (img_width)
  ) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .pixel_push   (pixel_push),
    .pixel        (pixel),
    .win_ok       (win_ok),
    .kernel       (kernel),
    .kernel_ready (kernel_ready)
  );

  line_window #(
    .img_width (img_width)
  ) u_window (
    .clk        (clk),
    .rst        (rst),
    .pixel_push (pixel_push),
    .pixel      (pixel),
    .win_ok     (win_ok),
    .window     (window)
  );

  conv55_clb u_clb (
    .clk    (clk),
    .rst    (rst),
    .window (window),
    .kernel (kernel),
    .result (result)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 16 rising edges
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== bench/conv_engine_sva.sv ====
`timescale 1ns/1ps

module conv_engine_sva (
  input logic                    clk,
  input logic                    rst,
  input conv_ctrl_pkg::cmd_t     cmd,
  input logic                    win_ok,
  input conv_types_pkg::result_t result,
  input logic                    kernel_ready
);

  // Output valid is cleared while reset is held
  a_reset_quiet: assert property (@(posedge clk) rst |=> !result.valid)
    else $error("result.valid high during reset");

  // Two edges from a pixel that completes a window to its result
  a_latency: assert property (@(posedge clk) disable iff (rst)
    win_ok |-> ##2 result.valid)
    else $error("no result two edges after a complete window");

  a_no_spurious: assert property (@(posedge clk) disable iff (rst)
    result.valid |-> $past(win_ok, 2))
    else $error("result.valid without a complete window two edges earlier");

  a_ready_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(kernel_ready) |-> $past(cmd.valid && cmd.op == conv_ctrl_pkg::op_coef))
    else $error("kernel_ready rose without a coefficient command");

endmodule

// ==== bench/conv_engine_tb.sv ====
`timescale 1ns/1ps

module conv_engine_tb;

  localparam int img_width = 8;

  logic                      clk;
  logic                      rst;
  conv_ctrl_pkg::cmd_t       cmd;
  conv_types_pkg::result_t   result;
  logic                      kernel_ready;
  conv_types_pkg::conv_sum_t exp_q [$];
  byte                       line_tag [$];
  int                        line_len [$];
  int                        vals [$];
  int                        errors = 0;
  int                        seed;
  bit                        parsed = 1'b0;

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  conv_engine_top #(
    .img_width (img_width)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .result       (result),
    .kernel_ready (kernel_ready)
  );

  bind conv_engine_top conv_engine_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .win_ok       (win_ok),
    .result       (result),
    .kernel_ready (kernel_ready)
  );

  task automatic check_sum(input conv_types_pkg::conv_sum_t got,
                           input conv_types_pkg::conv_sum_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] result.sum got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] kernel_ready got %h expected %h", got, exp);
    end
  endtask

  task automatic send_cmd(input conv_ctrl_pkg::cmd_op_e op, input int data);
    @(posedge clk);
    cmd <= '{valid: 1'b1, op: op, data: data[5:0]};
  endtask

  task automatic send_idle();
    @(posedge clk);
    cmd <= '0;
  endtask

  // Parse the whole file up front and queue the expected sums
  task automatic read_testdata();
    int    fd;
    int    code;
    int    v;
    int    n;
    byte   tag;
    string skip;
    fd = $fopen("bench/conv_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open bench/conv_testdata.txt");
      return;
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "K": n = 25;
        "P": n = img_width;
        "X": n = 2;
        "E": n = 1;
        "F": n = 0;
        default: n = -1;
      endcase
      if (n < 0) begin
        code = $fgets(skip, fd);
      end else begin
        line_tag.push_back(tag);
        line_len.push_back(n);
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, "%d", v);
          vals.push_back(v);
        end
        if (tag == "E") begin
          exp_q.push_back(conv_types_pkg::conv_sum_t'(v));
        end
      end
    end
    $fclose(fd);
  endtask

  always @(negedge clk) begin
    if (!rst && result.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Extra result with sum %h after all expected sums were used", result.sum);
      end else begin
        check_sum(result.sum, exp_q.pop_front());
      end
    end
  end

  initial begin
    wait (parsed);
    repeat (20 * line_tag.size() + 200) @(posedge clk);
    $display("Timeout, the run did not finish in time with %0d errors", errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int p;
    seed = 32'hd0a1;
    cmd = '0;
    read_testdata();
    parsed = 1'b1;
    @(negedge rst);
    @(negedge clk);
    check_flag(kernel_ready, 1'b0);
    p = 0;
    foreach (line_tag[i]) begin
      case (line_tag[i])
        "K": begin
          send_cmd(conv_ctrl_pkg::op_kernel_begin, 0);
          for (int k = 0; k < 25; k++) begin
            send_cmd(conv_ctrl_pkg::op_coef, vals[p+k]);
            if (k == 0) begin
              @(negedge clk);
              check_flag(kernel_ready, 1'b0);
            end
          end
          send_idle();
          @(negedge clk);
          check_flag(kernel_ready, 1'b1);
        end
        "F": send_cmd(conv_ctrl_pkg::op_frame_start, 0);
        "P": begin
          for (int k = 0; k < line_len[i]; k++) begin
            send_cmd(conv_ctrl_pkg::op_pixel, vals[p+k]);
          end
        end
        "X": begin
          // A full row of the same command, enough to complete a window if it were taken
          for (int k = 0; k < img_width; k++) begin
            send_cmd(conv_ctrl_pkg::cmd_op_e'(vals[p]), vals[p+1]);
          end
        end
        default: ;
      endcase
      p += line_len[i];
      if ($random(seed) & 1) begin
        send_idle();
      end
    end
    send_idle();
    for (int w = 0; w < 20 && exp_q.size() != 0; w++) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("Missing results, %0d expected sums never appeared", exp_q.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/conv_testdata.txt ====
# K 25 coefs, F frame start, P 8 pixels of one row, E expected sum, all decimal
# X out-of-state command as opcode then data (1 coef, 3 pixel)
K 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16 17 18 19 20 21 22 23 24 25
X 3 9
F
P 3 4 5 6 7 8 9 10
P 11 12 13 14 15 16 17 18
P 19 20 21 22 23 24 25 26
P 27 28 29 30 31 32 33 34
P 35 36 37 38 39 40 41 42
P 43 44 45 46 47 48 49 50
E 8875
E 9200
E 9525
E 9850
E 11475
E 11800
E 12125
E 12450
K 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63 63
X 3 9
F
P 63 63 63 63 63 63 63 63
P 63 63 63 63 63 63 63 63
P 63 63 63 63 63 63 63 63
X 1 5
P 63 63 63 63 63 63 63 63
P 63 63 63 63 63 63 63 63
E 99225
E 99225
E 99225
E 99225
F
P 1 3 5 7 9 11 13 15
P 2 4 6 8 10 12 14 16
P 3 5 7 9 11 13 15 17
X 1 0
P 4 6 8 10 12 14 16 18
P 5 7 9 11 13 15 17 19
P 6 8 10 12 14 16 18 20
E 11025
E 14175
E 17325
E 20475
E 12600
E 15750
E 18900
E 22050

// ==== files.f ====
source/conv_types_pkg.sv
source/conv_ctrl_pkg.sv
source/shift_add_mult.sv
source/adder_tree.sv
source/conv55_clb.sv
source/line_window.sv
source/conv_ctrl.sv
source/conv_engine_top.sv
bench/tb_clk_gen.sv
bench/conv_engine_sva.sv
bench/conv_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module conv_engine_tb \
  -f files.f -Mdir obj_dir || exit 1
obj_dir/Vconv_engine_tb > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
exit 0
